//--- bench/clock_gen.sv
// free-running clock from time zero; rstn is released 10 ns after the last reset edge
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 5
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#10 rstn = 1'b1;
	end

endmodule

`default_nettype wire

//--- bench/cluster_checker.sv
// cycle model compared on the falling edge; inputs may change only after the rising edge
`timescale 1ns/100ps
`default_nettype none

module cluster_checker
	import cluster_pkg::*;
(
	input  logic           clock,
	input  logic           rstn,
	input  logic           test_done,
	input  logic           enabled_in,
	input  logic           cfg_valid,
	input  cu_config_t     cfg_in,
	input  wed_t           wed_in,
	input  cfg_word_t      status,
	input  response_line_t read_response_in,
	input  data_line_t     read_data_in,
	input  response_line_t vertex_response_out,
	input  response_line_t algo_response_out,
	input  data_line_t     vertex_data_out,
	input  data_line_t     algo_data_out,
	input  command_line_t  vertex_cmd_in,
	input  command_line_t  algo_cmd_in,
	input  logic [1:0]     cmd_ready,
	input  buffer_status_t read_status,
	input  buffer_status_t write_status,
	input  command_line_t  read_command_out,
	input  logic           write_request,
	input  logic           write_grant,
	input  count_t         vertices_done,
	input  count_t         edges_done,
	input  count_t         vertices_filtered,
	input  cu_return_t     cu_return,
	input  logic           cu_done,
	output int             mismatch_count,
	output int             other_count
);

	// model state, each value as the DUT holds it after the last rising edge
	logic           en_q;
	logic           run_q;
	logic           wg_q;
	cu_config_t     cfg_q;
	wed_t           wed_q;
	response_line_t resp_pipe [2];
	data_line_t     data_pipe [2];
	logic [1:0]     slot_held;
	command_line_t  slot_cmd [2];
	int             last_served;
	command_line_t  cmd_q;
	count_t         done_prev;
	count_t         filt_prev;
	count_t         edges_prev;
	int             stable_cycles;
	int             issued;
	int             accepted;
	int             done_seen;
	int             vertex_seen;
	int             algo_seen;
	logic           final_done;

	//////////////////////
	// reference functions
	//////////////////////

	// nonzero words replace, zero words keep the stored value
	function automatic cu_config_t merge_config(cu_config_t old_words, cu_config_t new_words);
		cu_config_t result;
		result = old_words;
		for (int w = 0; w < NUM_CFG_WORDS; w++) begin
			if (new_words[w] != '0) begin
				result[w] = new_words[w];
			end
		end
		return result;
	endfunction

	function automatic logic goes_to_vertex(cu_id_t id);
		return id == VERTEX_CONTROL_ID;
	endfunction

	// with both held take the one not served last, otherwise whichever is held
	function automatic int pick_requester(logic [1:0] held, int last);
		if (held == 2'b11) begin
			return 1 - last;
		end
		return held[1] ? 1 : 0;
	endfunction

	function automatic cu_return_t expected_return(count_t done, count_t filtered, count_t edges);
		cu_return_t result;
		result.vertices = done + filtered;
		result.edges    = edges;
		return result;
	endfunction

	function automatic logic expected_done(cu_return_t ret, wed_t desc);
		return (ret.vertices == desc.num_vertices) && (ret.edges == desc.num_edges);
	endfunction

	//////////////////////
	// compare helpers
	//////////////////////

	task automatic compare_value(string what, logic [127:0] expected, logic [127:0] actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s expected %0h, got %0h", $time, what, expected, actual);
		end
	endtask

	task automatic compare_bit(string what, logic expected, logic actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s expected %b, got %b", $time, what, expected, actual);
		end
	endtask

	// payload only matters when the valid bit is expected
	task automatic compare_line(string what, logic exp_valid, logic [127:0] exp_line,
			logic got_valid, logic [127:0] got_line);
		compare_bit({what, " valid"}, exp_valid, got_valid);
		if (exp_valid && got_valid) begin
			compare_value(what, exp_line, got_line);
		end
	endtask

	//////////////////////
	// model
	//////////////////////

	task automatic reset_model();
		en_q          = 1'b0;
		run_q         = 1'b0;
		wg_q          = 1'b0;
		cfg_q         = '0;
		wed_q         = '0;
		resp_pipe[0]  = '0;
		resp_pipe[1]  = '0;
		data_pipe[0]  = '0;
		data_pipe[1]  = '0;
		slot_held     = 2'b00;
		// requester 0 goes first when both are held
		last_served   = 1;
		cmd_q         = '0;
		done_prev     = '0;
		filt_prev     = '0;
		edges_prev    = '0;
		stable_cycles = 0;
		issued        = 0;
		accepted      = 0;
		done_seen     = 0;
		vertex_seen   = 0;
		algo_seen     = 0;
		final_done    = 1'b0;
		mismatch_count = 0;
		other_count    = 0;
	endtask

	task automatic check_outputs();
		cu_return_t exp_return;
		logic       resp_vertex;
		logic       data_vertex;
		resp_vertex = goes_to_vertex(resp_pipe[1].cu_id);
		data_vertex = goes_to_vertex(data_pipe[1].cu_id);
		compare_value("status", 128'(cfg_q[0]), 128'(status));
		compare_line("vertex response", resp_pipe[1].valid && resp_vertex, 128'(resp_pipe[1]),
			vertex_response_out.valid, 128'(vertex_response_out));
		compare_line("algo response", resp_pipe[1].valid && !resp_vertex, 128'(resp_pipe[1]),
			algo_response_out.valid, 128'(algo_response_out));
		compare_line("vertex data", data_pipe[1].valid && data_vertex, 128'(data_pipe[1]),
			vertex_data_out.valid, 128'(vertex_data_out));
		compare_line("algo data", data_pipe[1].valid && !data_vertex, 128'(data_pipe[1]),
			algo_data_out.valid, 128'(algo_data_out));
		compare_value("cmd_ready", 128'(~slot_held & {2{~read_status.alfull}}), 128'(cmd_ready));
		compare_line("read command", cmd_q.valid, 128'(cmd_q),
			read_command_out.valid, 128'(read_command_out));
		compare_bit("write_grant", wg_q, write_grant);
		if (stable_cycles >= 4) begin
			exp_return = expected_return(done_prev, filt_prev, edges_prev);
			compare_value("cu_return", 128'(exp_return), 128'(cu_return));
			compare_bit("cu_done", expected_done(exp_return, wed_q), cu_done);
			if (cu_done) begin
				done_seen++;
			end
		end
		if (vertex_response_out.valid || vertex_data_out.valid) begin
			vertex_seen++;
		end
		if (algo_response_out.valid || algo_data_out.valid) begin
			algo_seen++;
		end
		if (read_command_out.valid) begin
			issued++;
		end
	endtask

	// steps the model across the next rising edge using the inputs now present
	task automatic advance_model();
		logic          run_next;
		logic          grant;
		logic          gate;
		int            pick;
		logic [1:0]    ready_now;
		command_line_t offered [2];
		run_next = (cfg_q[0] != '0) && wed_q.valid;

		resp_pipe[1] = resp_pipe[0];
		resp_pipe[0] = (en_q && read_response_in.valid) ? read_response_in : '0;
		data_pipe[1] = data_pipe[0];
		data_pipe[0] = (en_q && read_data_in.valid) ? read_data_in : '0;

		ready_now  = ~slot_held & {2{~read_status.alfull}};
		grant      = run_q && !read_status.alfull && (slot_held != 2'b00);
		cmd_q      = '0;
		if (grant) begin
			pick = pick_requester(slot_held, last_served);
			cmd_q = slot_cmd[pick];
			slot_held[pick] = 1'b0;
			last_served = pick;
		end
		offered[0] = vertex_cmd_in;
		offered[1] = algo_cmd_in;
		for (int r = 0; r < 2; r++) begin
			if (offered[r].valid && ready_now[r]) begin
				slot_held[r] = 1'b1;
				slot_cmd[r]  = offered[r];
				accepted++;
			end
		end

		wg_q = write_request && !write_status.alfull;

		// counts only travel while both enables are up
		gate = en_q && run_q;
		if (gate && vertices_done == done_prev && vertices_filtered == filt_prev
				&& edges_done == edges_prev) begin
			stable_cycles++;
		end else begin
			stable_cycles = gate ? 1 : 0;
		end
		done_prev  = vertices_done;
		filt_prev  = vertices_filtered;
		edges_prev = edges_done;

		if (en_q) begin
			wed_q = wed_in;
			if (cfg_valid) begin
				cfg_q = merge_config(cfg_q, cfg_in);
			end
		end
		run_q = run_next;
		en_q  = enabled_in;
	endtask

	task automatic final_checks();
		final_done = 1'b1;
		if (slot_held != 2'b00 || accepted != issued) begin
			other_count++;
			$display("arbiter issued %0d of %0d accepted commands", issued, accepted);
		end
		if (vertex_seen == 0 || algo_seen == 0) begin
			other_count++;
			$display("the routers never drove both the vertex and the algorithm outputs");
		end
		if (done_seen == 0) begin
			other_count++;
			$display("cu_done never went high while the counts matched the descriptor");
		end
	endtask

	always @(negedge clock) begin
		if (!rstn) begin
			reset_model();
		end else begin
			check_outputs();
			advance_model();
			if (test_done && !final_done) begin
				final_checks();
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/cluster_tb.sv
// inputs change 10 ns after the rising edge, command strobes 1 ns later once cmd_ready is settled
`timescale 1ns/100ps
`default_nettype none

module cluster_tb
	import cluster_pkg::*;
();

	localparam int     CLOCK_PERIOD  = 100;
	localparam int     RESET_CYCLES  = 5;
	localparam int     HOLD_CYCLES   = 12;
	localparam int     CONFIG_WRITES = 12;
	localparam int     ROUTE_CYCLES  = 200;
	localparam int     ARB_CYCLES    = 300;
	localparam int     DRAIN_CYCLES  = 20;
	localparam int     DONE_ROUNDS   = 12;
	localparam int     ROUND_CYCLES  = 8;
	localparam int     TOTAL_CYCLES  = RESET_CYCLES + HOLD_CYCLES + 3 * CONFIG_WRITES
		+ ROUTE_CYCLES + ARB_CYCLES + DRAIN_CYCLES + DONE_ROUNDS * ROUND_CYCLES + 8;
	localparam longint WATCHDOG_NS   = longint'(TOTAL_CYCLES + 200) * CLOCK_PERIOD;

	logic           clock;
	logic           rstn;
	logic           test_done;
	int             mismatch_count;
	int             other_count;
	int             bench_errors;
	int             cmd_seq;
	count_t         total_vertices;
	count_t         total_edges;

	logic           enabled_in;
	logic           cfg_valid;
	cu_config_t     cfg_in;
	wed_t           wed_in;
	cfg_word_t      status;
	response_line_t read_response_in;
	data_line_t     read_data_in;
	response_line_t vertex_response_out;
	response_line_t algo_response_out;
	data_line_t     vertex_data_out;
	data_line_t     algo_data_out;
	command_line_t  vertex_cmd_in;
	command_line_t  algo_cmd_in;
	logic [1:0]     cmd_ready;
	buffer_status_t read_status;
	buffer_status_t write_status;
	command_line_t  read_command_out;
	logic           write_request;
	logic           write_grant;
	count_t         vertices_done;
	count_t         edges_done;
	count_t         vertices_filtered;
	cu_return_t     cu_return;
	logic           cu_done;

	clock_gen #(
		.PERIOD       (CLOCK_PERIOD),
		.RESET_CYCLES (RESET_CYCLES)
	) clock_gen_i (
		.clock (clock),
		.rstn  (rstn)
	);

	cluster_control cluster_control_i (.*);

	cluster_checker cluster_checker_i (.*);

	//////////////////////
	// drive helpers
	//////////////////////

	// strobes drop every cycle, the write side is random throughout
	task automatic next_cycle();
		@(posedge clock);
		#10;
		cfg_valid              = 1'b0;
		read_response_in.valid = 1'b0;
		read_data_in.valid     = 1'b0;
		vertex_cmd_in.valid    = 1'b0;
		algo_cmd_in.valid      = 1'b0;
		write_request          = 1'($urandom_range(0, 1));
		write_status.alfull    = ($urandom_range(0, 3) == 0);
	endtask

	function automatic cfg_word_t random_word();
		return {$urandom, $urandom};
	endfunction

	// the tag carries the requester and a running number
	task automatic send_command(int req);
		command_line_t cmd;
		cmd.valid   = 1'b1;
		cmd.address = {16'($urandom), 32'($urandom)};
		cmd.tag     = {req[0], cmd_seq[14:0]};
		cmd_seq++;
		if (req == 0) begin
			vertex_cmd_in = cmd;
		end else begin
			algo_cmd_in = cmd;
		end
	endtask

	task automatic offer_commands(int chance);
		#1;
		for (int r = 0; r < 2; r++) begin
			if (cmd_ready[r] && $urandom_range(0, 99) < chance) begin
				send_command(r);
			end
		end
	endtask

	task automatic send_lines();
		if ($urandom_range(0, 9) < 7) begin
			read_response_in.valid = 1'b1;
			read_response_in.cu_id = 8'($urandom_range(0, 3));
			read_response_in.tag   = 16'($urandom);
		end
		if ($urandom_range(0, 9) < 7) begin
			read_data_in.valid = 1'b1;
			read_data_in.cu_id = 8'($urandom_range(0, 3));
			read_data_in.data  = {$urandom, $urandom};
		end
	endtask

	task automatic wait_for_drain();
		int waited;
		waited = 0;
		#1;
		while (cmd_ready != 2'b11 && waited < DRAIN_CYCLES) begin
			next_cycle();
			#1;
			waited++;
		end
		if (cmd_ready != 2'b11) begin
			bench_errors++;
			$display("arbiter slots still held after %0d cycles", DRAIN_CYCLES);
		end
	endtask

	// matching rounds split the vertex total between done and filtered
	task automatic hold_counts(bit matching);
		count_t filtered;
		filtered          = $urandom_range(0, total_vertices);
		vertices_filtered = filtered;
		vertices_done     = total_vertices - filtered;
		edges_done        = total_edges;
		if (!matching) begin
			if ($urandom_range(0, 1) == 1) begin
				vertices_done = vertices_done + 1;
			end else begin
				edges_done = edges_done - 1;
			end
		end
		repeat (ROUND_CYCLES) next_cycle();
	endtask

	//////////////////////
	// stimulus
	//////////////////////

	initial begin
		int seed;
		seed              = $urandom(99467);
		test_done         = 1'b0;
		bench_errors      = 0;
		cmd_seq           = 0;
		enabled_in        = 1'b0;
		cfg_valid         = 1'b0;
		cfg_in            = '0;
		wed_in            = '0;
		read_response_in  = '0;
		read_data_in      = '0;
		vertex_cmd_in     = '0;
		algo_cmd_in       = '0;
		read_status       = 2'b01;
		write_status      = 2'b01;
		write_request     = 1'b0;
		vertices_done     = '0;
		edges_done        = '0;
		vertices_filtered = '0;
		total_vertices    = $urandom_range(100, 1000);
		total_edges       = $urandom_range(100, 4000);

		@(posedge rstn);
		next_cycle();
		enabled_in = 1'b1;
		// both slots fill while run_enable is still low
		next_cycle();
		offer_commands(100);
		repeat (HOLD_CYCLES - 2) next_cycle();

		wed_in.valid        = 1'b1;
		wed_in.num_vertices = total_vertices;
		wed_in.num_edges    = total_edges;
		for (int i = 0; i < CONFIG_WRITES; i++) begin
			next_cycle();
			cfg_valid = 1'b1;
			for (int w = 0; w < NUM_CFG_WORDS; w++) begin
				cfg_in[w] = ($urandom_range(0, 2) == 0) ? '0 : random_word();
			end
			// word 0 stays empty on the first write and is set on the second
			if (i == 0) begin
				cfg_in[0] = '0;
			end
			if (i == 1) begin
				cfg_in[0] = random_word();
			end
			repeat (2) next_cycle();
		end

		for (int c = 0; c < ROUTE_CYCLES; c++) begin
			next_cycle();
			enabled_in = !(c >= 80 && c < 100);
			send_lines();
		end

		for (int c = 0; c < ARB_CYCLES; c++) begin
			next_cycle();
			read_status.alfull = ($urandom_range(0, 4) == 0);
			offer_commands(60);
		end
		next_cycle();
		read_status.alfull = 1'b0;
		wait_for_drain();

		for (int r = 0; r < DONE_ROUNDS; r++) begin
			hold_counts(r % 2 == 0);
		end

		test_done = 1'b1;
		repeat (3) next_cycle();
		$display("mismatches: %0d, other errors: %0d", mismatch_count,
			other_count + bench_errors);
		if (mismatch_count == 0 && other_count + bench_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("run timed out after %0d ns", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
logic/cluster_pkg.sv
logic/cluster_config_regs.sv
logic/response_router.sv
logic/command_bus_arbiter.sv
logic/completion_tracker.sv
logic/cluster_control.sv
bench/clock_gen.sv
bench/cluster_checker.sv
bench/cluster_tb.sv

//--- logic/cluster_config_regs.sv
// zero words are never stored, so a configuration word cannot be cleared by a write, only by rstn
`timescale 1ns/100ps
`default_nettype none

module cluster_config_regs
	import cluster_pkg::*;
(
	input  logic       clock,
	input  logic       rstn,
	input  logic       enabled_in,
	input  logic       cfg_valid,
	input  cu_config_t cfg_in,
	input  wed_t       wed_in,
	output logic       enabled,
	output logic       run_enable,
	output wed_t       wed,
	output cfg_word_t  status
);

	cu_config_t cfg_words;

	//////////////////////
	// enables
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled    <= 1'b0;
			run_enable <= 1'b0;
		end else begin
			enabled <= enabled_in;
			// work may start once word 0 is set and a descriptor is held
			run_enable <= (|cfg_words[0]) && wed.valid;
		end
	end

	//////////////////////
	// descriptor and words
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed       <= '0;
			cfg_words <= '0;
		end else if (enabled) begin
			wed <= wed_in;
			if (cfg_valid) begin
				for (int w = 0; w < NUM_CFG_WORDS; w++) begin
					// a zero word keeps what was there
					if (|cfg_in[w]) begin
						cfg_words[w] <= cfg_in[w];
					end
				end
			end
		end
	end

	assign status = cfg_words[0];

endmodule

`default_nettype wire

//--- logic/cluster_control.sv
// compute units live outside; requester 0 is the vertex-job path, requester 1 the algorithm path
`timescale 1ns/100ps
`default_nettype none

module cluster_control
	import cluster_pkg::*;
#(
	parameter cu_id_t VERTEX_ID = VERTEX_CONTROL_ID
) (
	input  logic           clock,
	input  logic           rstn,

	// configuration
	input  logic           enabled_in,
	input  logic           cfg_valid,
	input  cu_config_t     cfg_in,
	input  wed_t           wed_in,
	output cfg_word_t      status,

	// responses and read data
	input  response_line_t read_response_in,
	input  data_line_t     read_data_in,
	output response_line_t vertex_response_out,
	output response_line_t algo_response_out,
	output data_line_t     vertex_data_out,
	output data_line_t     algo_data_out,

	// command buses
	input  command_line_t  vertex_cmd_in,
	input  command_line_t  algo_cmd_in,
	output logic [1:0]     cmd_ready,
	input  buffer_status_t read_status,
	input  buffer_status_t write_status,
	output command_line_t  read_command_out,
	input  logic           write_request,
	output logic           write_grant,

	// completion
	input  count_t         vertices_done,
	input  count_t         edges_done,
	input  count_t         vertices_filtered,
	output cu_return_t     cu_return,
	output logic           cu_done
);

	logic enabled;
	logic run_enable;
	wed_t wed;

	cluster_config_regs config_regs_i (
		.clock      (clock),
		.rstn       (rstn),
		.enabled_in (enabled_in),
		.cfg_valid  (cfg_valid),
		.cfg_in     (cfg_in),
		.wed_in     (wed_in),
		.enabled    (enabled),
		.run_enable (run_enable),
		.wed        (wed),
		.status     (status)
	);

	//////////////////////
	// routing
	//////////////////////

	response_router #(
		.payload_t (response_line_t),
		.VERTEX_ID (VERTEX_ID)
	) response_router_i (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.line_in    (read_response_in),
		.vertex_out (vertex_response_out),
		.algo_out   (algo_response_out)
	);

	response_router #(
		.payload_t (data_line_t),
		.VERTEX_ID (VERTEX_ID)
	) data_router_i (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.line_in    (read_data_in),
		.vertex_out (vertex_data_out),
		.algo_out   (algo_data_out)
	);

	//////////////////////
	// arbitration
	//////////////////////

	command_bus_arbiter command_bus_arbiter_i (
		.clock            (clock),
		.rstn             (rstn),
		.run_enable       (run_enable),
		.cmd_in           ({algo_cmd_in, vertex_cmd_in}),
		.ready            (cmd_ready),
		.read_status      (read_status),
		.read_command_out (read_command_out),
		.write_request    (write_request),
		.write_status     (write_status),
		.write_grant      (write_grant)
	);

	//////////////////////
	// completion
	//////////////////////

	completion_tracker completion_tracker_i (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.run_enable        (run_enable),
		.wed               (wed),
		.vertices_done     (vertices_done),
		.edges_done        (edges_done),
		.vertices_filtered (vertices_filtered),
		.cu_return         (cu_return),
		.cu_done           (cu_done)
	);

endmodule

`default_nettype wire

//--- logic/cluster_pkg.sv
// shared types for the cluster shell; field widths are fixed here and every rtl file leans on them
`default_nettype none

package cluster_pkg;

	//////////////////////
	// constants
	//////////////////////

	// compute-unit id that marks vertex-job traffic
	localparam logic [7:0] VERTEX_CONTROL_ID = 8'd1;

	// configuration words held by the register block
	localparam int NUM_CFG_WORDS = 4;

	//////////////////////
	// scalar types
	//////////////////////

	typedef logic [7:0]  cu_id_t;
	typedef logic [31:0] count_t;
	typedef logic [63:0] cfg_word_t;

	// word 0 sits in the low slot
	typedef cfg_word_t [NUM_CFG_WORDS-1:0] cu_config_t;

	//////////////////////
	// bus lines
	//////////////////////

	// work descriptor with the job totals
	typedef struct packed {
		logic   valid;
		count_t num_vertices;
		count_t num_edges;
	} wed_t;

	typedef struct packed {
		logic        valid;
		cu_id_t      cu_id;
		logic [15:0] tag;
	} response_line_t;

	typedef struct packed {
		logic        valid;
		cu_id_t      cu_id;
		logic [63:0] data;
	} data_line_t;

	typedef struct packed {
		logic        valid;
		logic [47:0] address;
		logic [15:0] tag;
	} command_line_t;

	// values handed back on completion
	typedef struct packed {
		count_t vertices;
		count_t edges;
	} cu_return_t;

	typedef struct packed {
		logic alfull;
		logic empty;
	} buffer_status_t;

endpackage

`default_nettype wire

//--- logic/command_bus_arbiter.sv
// two requesters only, one slot each; a requester must not strobe while its ready is low
`timescale 1ns/100ps
`default_nettype none

module command_bus_arbiter
	import cluster_pkg::*;
(
	input  logic                clock,
	input  logic                rstn,
	input  logic                run_enable,
	input  command_line_t [1:0] cmd_in,
	output logic [1:0]          ready,
	input  buffer_status_t      read_status,
	output command_line_t       read_command_out,
	input  logic                write_request,
	input  buffer_status_t      write_status,
	output logic                write_grant
);

	localparam int NUM_REQ = 2;

	logic [NUM_REQ-1:0]          slot_valid;
	command_line_t [NUM_REQ-1:0] slot_cmd;
	logic                        grant_valid;
	logic                        grant_idx;
	logic [NUM_REQ-1:0]          grant_vec;
	logic                        last_idx;
	logic                        out_valid;
	command_line_t               out_cmd;

	// empty slots accept, except while the read buffer is nearly full
	assign ready = ~slot_valid & {NUM_REQ{~read_status.alfull}};

	//////////////////////
	// round robin pick
	//////////////////////

	always_comb begin
		grant_valid = run_enable && !read_status.alfull && (|slot_valid);
		// both held: take the one not served last, otherwise the only one held
		grant_idx = slot_valid[1] && !(slot_valid[0] && last_idx);
		grant_vec = {grant_valid && grant_idx, grant_valid && !grant_idx};
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			slot_valid <= '0;
			last_idx   <= 1'b1;
			out_valid  <= 1'b0;
		end else begin
			for (int n = 0; n < NUM_REQ; n++) begin
				if (grant_vec[n]) begin
					slot_valid[n] <= 1'b0;
				end else if (cmd_in[n].valid) begin
					slot_valid[n] <= 1'b1;
				end
			end
			if (grant_valid) begin
				last_idx <= grant_idx;
			end
			out_valid <= grant_valid;
		end
	end

	always_ff @(posedge clock) begin
		for (int n = 0; n < NUM_REQ; n++) begin
			if (cmd_in[n].valid && ready[n]) begin
				slot_cmd[n] <= cmd_in[n];
			end
		end
		out_cmd <= slot_cmd[grant_idx];
	end

	always_comb begin
		read_command_out       = out_cmd;
		read_command_out.valid = out_valid;
	end

	//////////////////////
	// write bus
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_grant <= 1'b0;
		end else begin
			write_grant <= write_request && !write_status.alfull;
		end
	end

	// requesters sit in other blocks and must honour ready
	for (genvar g = 0; g < NUM_REQ; g++) begin : g_strobe_check
		a_no_overrun: assert property (@(posedge clock) disable iff (!rstn)
			cmd_in[g].valid |-> ready[g]);
	end

endmodule

`default_nettype wire

//--- logic/completion_tracker.sv
// counts must be held stable for 4 cycles before cu_done and cu_return can be trusted
`timescale 1ns/100ps
`default_nettype none

module completion_tracker
	import cluster_pkg::*;
(
	input  logic       clock,
	input  logic       rstn,
	input  logic       enabled,
	input  logic       run_enable,
	input  wed_t       wed,
	input  count_t     vertices_done,
	input  count_t     edges_done,
	input  count_t     vertices_filtered,
	output cu_return_t cu_return,
	output logic       cu_done
);

	count_t     vertices_done_q;
	count_t     edges_done_q;
	count_t     vertices_filtered_q;
	count_t     vertices_total;
	count_t     edges_total;
	cu_return_t return_q;
	logic       match_q;

	//////////////////////
	// stages 1 and 2
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertices_done_q     <= '0;
			edges_done_q        <= '0;
			vertices_filtered_q <= '0;
			vertices_total      <= '0;
			edges_total         <= '0;
		end else if (enabled) begin
			vertices_done_q     <= vertices_done;
			edges_done_q        <= edges_done;
			vertices_filtered_q <= vertices_filtered;
			// filtered vertices count as processed
			vertices_total <= vertices_done_q + vertices_filtered_q;
			edges_total    <= edges_done_q;
		end
	end

	//////////////////////
	// stage 3 compare
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			return_q <= '0;
			match_q  <= 1'b0;
		end else if (enabled && run_enable) begin
			return_q.vertices <= vertices_total;
			return_q.edges    <= edges_total;
			match_q <= (wed.num_vertices == vertices_total) && (wed.num_edges == edges_total);
		end
	end

	//////////////////////
	// stage 4 outputs
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_return <= '0;
			cu_done   <= 1'b0;
		end else if (enabled) begin
			cu_return <= return_q;
			cu_done   <= match_q;
		end
	end

endmodule

`default_nettype wire

//--- logic/response_router.sv
// payload_t must carry valid and cu_id; items that arrive while disabled are dropped
`timescale 1ns/100ps
`default_nettype none

module response_router
	import cluster_pkg::*;
#(
	parameter type    payload_t = response_line_t,
	parameter cu_id_t VERTEX_ID = VERTEX_CONTROL_ID
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     enabled,
	input  payload_t line_in,
	output payload_t vertex_out,
	output payload_t algo_out
);

	logic     stage1_valid;
	payload_t stage1_line;
	logic     vertex_valid;
	logic     algo_valid;
	payload_t stage2_line;

	//////////////////////
	// stage 1 capture
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			stage1_valid <= 1'b0;
		end else begin
			stage1_valid <= enabled && line_in.valid;
		end
	end

	always_ff @(posedge clock) begin
		stage1_line <= line_in;
	end

	//////////////////////
	// stage 2 steer
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_valid <= 1'b0;
			algo_valid   <= 1'b0;
		end else begin
			// idle cycles clear both sides
			vertex_valid <= stage1_valid && (stage1_line.cu_id == VERTEX_ID);
			algo_valid   <= stage1_valid && (stage1_line.cu_id != VERTEX_ID);
		end
	end

	// both outputs share one payload register
	always_ff @(posedge clock) begin
		stage2_line <= stage1_line;
	end

	always_comb begin
		vertex_out       = stage2_line;
		vertex_out.valid = vertex_valid;
		algo_out         = stage2_line;
		algo_out.valid   = algo_valid;
	end

	//////////////////////
	// checks
	//////////////////////

	a_one_side: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_out.valid && algo_out.valid));

endmodule

`default_nettype wire
